/* sources.f */
verilog/isa_pkg.sv
verilog/rob_pkg.sv
verilog/rob_dispatch_decode.sv
verilog/rob_buffer.sv
verilog/arch_regfile.sv
verilog/rob_top.sv
test/rob_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the ROB testbench with Verilator and run it
# Exit status is the simulator's: nonzero on any $fatal
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert \
    --timescale 1ns/10ps \
    -f sources.f \
    --top-module rob_tb \
    -o rob_sim \
    && ./obj_dir/rob_sim \
    || { echo "Simulation did not complete cleanly" >&2; exit 1; }
echo "Simulation finished"

/* test/rob_tb.sv */
`timescale 1ns/10ps

module rob_tb;
    import isa_pkg::*;
    import rob_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int DRAIN_CYCLES = 64;

    typedef struct packed {
        logic [XLEN-1:0] inst;                          // Zero word is a bubble
        logic [XLEN-1:0] pc;
        logic            exp_wr;                        // Expected commit write flag
        logic [1:0]      unit;                          // 0 none, 1 ALU, 2 MUL, 3 DIV
        logic [XLEN-1:0] cpl_pc;
        logic [XLEN-1:0] cpl_value;
        logic            br;
        logic            br_taken;                      // Mispredict
        logic [XLEN-1:0] br_pc;
        logic [XLEN-1:0] br_target;
        logic            flush;
    } row_t;

    typedef struct packed {
        logic [XLEN-1:0]      pc;
        logic [REG_IDX_W-1:0] dest;
        logic                 wr;
        logic                 br;
        logic [XLEN-1:0]      value;
        logic                 ready;
    } entry_t;

    logic                 clk, rst, rob_flush;
    logic [XLEN-1:0]      inst, inst_pc;
    logic                 alu_done, mul_done, div_done, br_done, br_taken;
    logic [XLEN-1:0]      alu_pc, alu_value, mul_pc, mul_value, div_pc, div_value;
    logic [XLEN-1:0]      br_pc, br_target;
    logic [REG_IDX_W-1:0] rf_raddr;
    logic                 rob_full, commit_valid, commit_reg_write;
    logic [XLEN-1:0]      commit_pc, commit_value, rf_rdata;
    logic [REG_IDX_W-1:0] commit_dest;

    row_t                 rows[$];                      // Stimulus table
    string                names[$];                     // Test name per row
    entry_t               model_q[$];                   // Entries in flight, head first
    logic [XLEN-1:0]      shadow_regs [NUM_ARCH_REGS];  // Last committed value per reg
    logic                 exp_valid, exp_wr, exp_full;
    logic [XLEN-1:0]      exp_pc, exp_value;
    logic [REG_IDX_W-1:0] exp_dest;
    string                cur_name = "reset";
    int                   seed;
    int                   cycle_count = 0;
    int                   timeout_limit = 0;

    rob_top u_rob_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                         // 20 ns period
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("Run hung: no end after %0d cycles", timeout_limit);
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(string field, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
        $display("FAIL %s %s: expected %h, actual %h", cur_name, field, exp, act);
        stop_with_failure();
    endtask

    task automatic check_outputs();
        assert (commit_valid === exp_valid)
            else report_mismatch("commit_valid", XLEN'(exp_valid), XLEN'(commit_valid));
        assert (rob_full === exp_full)
            else report_mismatch("rob_full", XLEN'(exp_full), XLEN'(rob_full));
        if (exp_valid) begin                            // Payload only on a commit
            assert (commit_pc === exp_pc)
                else report_mismatch("commit_pc", exp_pc, commit_pc);
            assert (commit_dest === exp_dest)
                else report_mismatch("commit_dest", XLEN'(exp_dest), XLEN'(commit_dest));
            assert (commit_value === exp_value)
                else report_mismatch("commit_value", exp_value, commit_value);
            assert (commit_reg_write === exp_wr)
                else report_mismatch("commit_reg_write", XLEN'(exp_wr), XLEN'(commit_reg_write));
        end
        assert (rf_rdata === '0)                        // rf_raddr parked on x0
            else report_mismatch("rf_rdata x0", '0, rf_rdata);
    endtask

    task automatic drive_row(row_t r);
        inst      = r.inst;
        inst_pc   = r.pc;
        alu_done  = (r.unit == 2'd1);
        mul_done  = (r.unit == 2'd2);
        div_done  = (r.unit == 2'd3);
        alu_pc    = (r.unit == 2'd1) ? r.cpl_pc : ~r.cpl_pc;     // Idle units off the key
        mul_pc    = (r.unit == 2'd2) ? r.cpl_pc : ~r.cpl_pc;
        div_pc    = (r.unit == 2'd3) ? r.cpl_pc : ~r.cpl_pc;
        alu_value = (r.unit == 2'd1) ? r.cpl_value : ~r.cpl_value; // Distinct per unit
        mul_value = (r.unit == 2'd2) ? r.cpl_value : ~r.cpl_value;
        div_value = (r.unit == 2'd3) ? r.cpl_value : ~r.cpl_value;
        br_done   = r.br;
        br_taken  = r.br_taken;
        br_pc     = r.br_pc;
        br_target = r.br_target;
        rob_flush = r.flush;
    endtask

    // Predicts the outputs that the coming rising edge produces
    task automatic model_step(row_t r);
        entry_t e;
        logic   fire;
        logic   full_before;
        int     br_idx;
        fire        = (model_q.size() > 0) && model_q[0].ready;
        full_before = (model_q.size() == ROB_DEPTH);
        br_idx      = -1;
        exp_valid   = fire;
        if (fire) begin
            exp_pc    = model_q[0].pc;
            exp_dest  = model_q[0].dest;
            exp_value = model_q[0].value;
            exp_wr    = model_q[0].wr;
        end
        if (r.flush) begin
            model_q.delete();                           // Flush beats commit
            exp_valid = 1'b0;
        end else begin
            for (int i = 0; i < model_q.size(); i++) begin
                e = model_q[i];
                if (r.unit != 2'd0 && e.pc == r.cpl_pc) begin
                    e.value = r.cpl_value;
                    e.ready = 1'b1;
                end
                if (r.br && e.br && e.pc == r.br_pc) begin
                    e.value = r.br_target;
                    e.ready = 1'b1;
                    if (r.br_taken) br_idx = i;
                end
                model_q[i] = e;
            end
            if (br_idx >= 0) begin
                while (model_q.size() > br_idx + 1) void'(model_q.pop_back()); // Wrong path
            end else if (r.inst != '0 && !full_before) begin
                e.pc    = r.pc;
                e.dest  = r.inst[RD_LSB +: REG_IDX_W];
                e.wr    = r.exp_wr;
                e.br    = (r.inst[OPC_W-1:0] == OPC_BRANCH);
                e.value = '0;
                e.ready = 1'b0;
                model_q.push_back(e);
            end
            if (fire) begin
                e = model_q.pop_front();
                if (e.wr) shadow_regs[e.dest] = e.value;
            end
        end
        exp_full = (model_q.size() == ROB_DEPTH);
    endtask

    task automatic store_row(string name, row_t r);
        names.push_back(name);
        rows.push_back(r);
    endtask

    task automatic dispatch_inst(string name, logic [OPC_W-1:0] opc,
                                 logic [REG_IDX_W-1:0] rd, logic [XLEN-1:0] pc,
                                 logic wr);
        row_t r;
        r        = '0;
        r.inst   = {20'h00abc, rd, opc};                // Filler bits keep the word nonzero
        r.pc     = pc;
        r.exp_wr = wr;
        store_row(name, r);
    endtask

    task automatic complete_pc(string name, logic [1:0] unit, logic [XLEN-1:0] pc);
        row_t r;
        r           = '0;
        r.unit      = unit;
        r.cpl_pc    = pc;
        r.cpl_value = $random(seed);
        store_row(name, r);
    endtask

    task automatic resolve_branch(string name, logic [XLEN-1:0] pc, logic taken,
                                  logic [XLEN-1:0] target);
        row_t r;
        r           = '0;
        r.br        = 1'b1;
        r.br_taken  = taken;
        r.br_pc     = pc;
        r.br_target = target;
        store_row(name, r);
    endtask

    task automatic idle_cycles(string name, int n);
        for (int i = 0; i < n; i++) store_row(name, '0);
    endtask

    task automatic flush_all(string name);
        row_t r;
        r       = '0;
        r.flush = 1'b1;
        store_row(name, r);
    endtask

    task automatic build_table();
        for (int i = 0; i < 6; i++) begin
            dispatch_inst("ooo", OPC_OP, 5'(i + 1), 32'h100 + 32'(4 * i), 1'b1);
        end
        for (int i = 5; i >= 0; i--) complete_pc("ooo", 2'(i % 3 + 1), 32'h100 + 32'(4 * i));
        idle_cycles("ooo drain", 8);
        idle_cycles("bubble", 2);
        dispatch_inst("store", OPC_STORE, 5'd5, 32'h204, 1'b0);
        dispatch_inst("x0 write", OPC_OP_IMM, 5'd0, 32'h208, 1'b0);
        dispatch_inst("lui", OPC_LUI, 5'd7, 32'h20c, 1'b1);
        dispatch_inst("jal", OPC_JAL, 5'd1, 32'h210, 1'b1);
        complete_pc("nowrite", 2'd1, 32'h210);
        complete_pc("nowrite", 2'd2, 32'h204);
        complete_pc("nowrite", 2'd1, 32'h20c);
        complete_pc("nowrite", 2'd3, 32'h208);
        idle_cycles("nowrite drain", 6);
        dispatch_inst("br ok", OPC_BRANCH, 5'd2, 32'h300, 1'b0);
        dispatch_inst("br ok", OPC_OP, 5'd8, 32'h304, 1'b1);
        dispatch_inst("br ok", OPC_AUIPC, 5'd9, 32'h308, 1'b1);
        complete_pc("br ok", 2'd3, 32'h308);
        complete_pc("br ok", 2'd2, 32'h304);
        resolve_branch("br ok resolve", 32'h300, 1'b0, 32'h400);
        idle_cycles("br ok drain", 6);
        dispatch_inst("mispredict", OPC_OP, 5'd10, 32'h500, 1'b1);
        dispatch_inst("mispredict", OPC_BRANCH, 5'd3, 32'h504, 1'b0);
        dispatch_inst("mispredict", OPC_OP, 5'd11, 32'h508, 1'b1);
        dispatch_inst("mispredict", OPC_JALR, 5'd12, 32'h50c, 1'b1);
        complete_pc("mispredict", 2'd1, 32'h500);
        complete_pc("mispredict", 2'd2, 32'h508);   // Younger, ready but discarded later
        resolve_branch("mispredict resolve", 32'h504, 1'b1, 32'h600);
        complete_pc("stale result", 2'd3, 32'h50c);
        complete_pc("stale result", 2'd1, 32'h508);
        dispatch_inst("new path", OPC_OP, 5'd13, 32'h600, 1'b1);
        dispatch_inst("new path", OPC_OP, 5'd14, 32'h604, 1'b1);
        complete_pc("new path", 2'd1, 32'h604);
        complete_pc("new path", 2'd2, 32'h600);
        idle_cycles("new path drain", 6);
        for (int i = 0; i < ROB_DEPTH; i++) begin
            dispatch_inst("fill", OPC_OP, 5'(i % 31 + 1), 32'h1000 + 32'(4 * i), 1'b1);
        end
        flush_all("flush");
        complete_pc("after flush", 2'd1, 32'h1000);  // Matches nothing now
        idle_cycles("after flush", 4);
        dispatch_inst("restart", OPC_LOAD, 5'd20, 32'h2000, 1'b1);
        complete_pc("restart", 2'd3, 32'h2000);
        idle_cycles("restart drain", 4);
    endtask

    initial begin
        seed = 32'hf184_33d7;
        build_table();
        timeout_limit = rows.size() + DRAIN_CYCLES + RESET_CYCLES;
        rst       = 1'b1;
        rf_raddr  = '0;
        drive_row('0);
        exp_valid = 1'b0;
        exp_wr    = 1'b0;
        exp_full  = 1'b0;
        for (int i = 0; i < NUM_ARCH_REGS; i++) shadow_regs[i] = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        for (int k = 0; k < rows.size(); k++) begin
            @(negedge clk);
            check_outputs();                            // Result of the previous row
            cur_name = names[k];
            drive_row(rows[k]);
            model_step(rows[k]);
        end
        cur_name = "drain";
        while (model_q.size() != 0 || exp_valid) begin
            @(negedge clk);
            check_outputs();
            drive_row('0);
            model_step('0);
        end
        @(negedge clk);
        check_outputs();
        cur_name = "regfile read";
        for (int r = 0; r < NUM_ARCH_REGS; r++) begin
            @(negedge clk);
            rf_raddr = 5'(r);
            #5;                                         // Combinational read settles
            assert (rf_rdata === shadow_regs[r])
                else report_mismatch($sformatf("x%0d", r), shadow_regs[r], rf_rdata);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* verilog/rob_top.sv */
`timescale 1ns/10ps

module rob_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rob_flush,
    // Front end
    input  logic [isa_pkg::XLEN-1:0]      inst,
    input  logic [isa_pkg::XLEN-1:0]      inst_pc,
    // Execution units
    input  logic                          alu_done,
    input  logic [isa_pkg::XLEN-1:0]      alu_pc,
    input  logic [isa_pkg::XLEN-1:0]      alu_value,
    input  logic                          mul_done,
    input  logic [isa_pkg::XLEN-1:0]      mul_pc,
    input  logic [isa_pkg::XLEN-1:0]      mul_value,
    input  logic                          div_done,
    input  logic [isa_pkg::XLEN-1:0]      div_pc,
    input  logic [isa_pkg::XLEN-1:0]      div_value,
    // Branch unit
    input  logic                          br_done,
    input  logic                          br_taken,
    input  logic [isa_pkg::XLEN-1:0]      br_pc,
    input  logic [isa_pkg::XLEN-1:0]      br_target,
    // Register file read port
    input  logic [isa_pkg::REG_IDX_W-1:0] rf_raddr,
    // Status and commit
    output logic                          rob_full,
    output logic                          commit_valid,
    output logic [isa_pkg::XLEN-1:0]      commit_pc,
    output logic [isa_pkg::REG_IDX_W-1:0] commit_dest,
    output logic [isa_pkg::XLEN-1:0]      commit_value,
    output logic                          commit_reg_write,
    output logic [isa_pkg::XLEN-1:0]      rf_rdata
);
    import isa_pkg::*;

    logic                 dec_alloc;                    // Decoder to buffer
    logic [REG_IDX_W-1:0] dec_dest;
    logic                 dec_writes_reg;
    logic                 dec_is_branch;

    rob_dispatch_decode u_decode (
        .inst       (inst),
        .alloc      (dec_alloc),
        .dest       (dec_dest),
        .writes_reg (dec_writes_reg),
        .is_branch  (dec_is_branch)
    );

    rob_buffer u_buffer (
        .clk              (clk),
        .rst              (rst),
        .rob_flush        (rob_flush),
        .alloc            (dec_alloc),
        .alloc_pc         (inst_pc),
        .alloc_dest       (dec_dest),
        .alloc_writes_reg (dec_writes_reg),
        .alloc_is_branch  (dec_is_branch),
        .alu_done         (alu_done),
        .alu_pc           (alu_pc),
        .alu_value        (alu_value),
        .mul_done         (mul_done),
        .mul_pc           (mul_pc),
        .mul_value        (mul_value),
        .div_done         (div_done),
        .div_pc           (div_pc),
        .div_value        (div_value),
        .br_done          (br_done),
        .br_taken         (br_taken),
        .br_pc            (br_pc),
        .br_target        (br_target),
        .rob_full         (rob_full),
        .commit_valid     (commit_valid),
        .commit_pc        (commit_pc),
        .commit_dest      (commit_dest),
        .commit_value     (commit_value),
        .commit_reg_write (commit_reg_write)
    );

    // Commit port drives the architectural write
    arch_regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (commit_valid && commit_reg_write),
        .wr_addr (commit_dest),
        .wr_data (commit_value),
        .rd_addr (rf_raddr),
        .rd_data (rf_rdata)
    );

endmodule

/* verilog/arch_regfile.sv */
`timescale 1ns/10ps

module arch_regfile (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wr_en,        // From commit
    input  logic [isa_pkg::REG_IDX_W-1:0] wr_addr,
    input  logic [isa_pkg::XLEN-1:0]      wr_data,
    input  logic [isa_pkg::REG_IDX_W-1:0] rd_addr,
    output logic [isa_pkg::XLEN-1:0]      rd_data       // Combinational read
);
    import isa_pkg::*;

    logic [XLEN-1:0] regs [NUM_ARCH_REGS];              // x0 never written

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data = regs[rd_addr];

endmodule

/* verilog/rob_buffer.sv */
`timescale 1ns/10ps

module rob_buffer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rob_flush,        // Clears every entry
    // Dispatch
    input  logic                          alloc,
    input  logic [isa_pkg::XLEN-1:0]      alloc_pc,
    input  logic [isa_pkg::REG_IDX_W-1:0] alloc_dest,
    input  logic                          alloc_writes_reg,
    input  logic                          alloc_is_branch,
    // Completion by PC
    input  logic                          alu_done,
    input  logic [isa_pkg::XLEN-1:0]      alu_pc,
    input  logic [isa_pkg::XLEN-1:0]      alu_value,
    input  logic                          mul_done,
    input  logic [isa_pkg::XLEN-1:0]      mul_pc,
    input  logic [isa_pkg::XLEN-1:0]      mul_value,
    input  logic                          div_done,
    input  logic [isa_pkg::XLEN-1:0]      div_pc,
    input  logic [isa_pkg::XLEN-1:0]      div_value,
    // Branch resolution
    input  logic                          br_done,
    input  logic                          br_taken,         // Mispredict
    input  logic [isa_pkg::XLEN-1:0]      br_pc,
    input  logic [isa_pkg::XLEN-1:0]      br_target,
    // Status and commit
    output logic                          rob_full,
    output logic                          commit_valid,
    output logic [isa_pkg::XLEN-1:0]      commit_pc,
    output logic [isa_pkg::REG_IDX_W-1:0] commit_dest,
    output logic [isa_pkg::XLEN-1:0]      commit_value,
    output logic                          commit_reg_write
);
    import isa_pkg::*;
    import rob_pkg::*;

    // Per-entry state
    logic                 ent_valid [ROB_DEPTH];        // Entry in flight
    logic                 ent_ready [ROB_DEPTH];        // Result present
    logic                 ent_wr    [ROB_DEPTH];        // Writes rd on commit
    logic                 ent_br    [ROB_DEPTH];        // Branch entry
    logic [REG_IDX_W-1:0] ent_dest  [ROB_DEPTH];
    logic [XLEN-1:0]      ent_pc    [ROB_DEPTH];        // Match key for results
    logic [XLEN-1:0]      ent_value [ROB_DEPTH];

    logic [ROB_IDX_W-1:0] head;                         // Oldest entry
    logic [ROB_IDX_W-1:0] tail;                         // Next free slot
    logic [ROB_CNT_W-1:0] count;                        // Occupancy

    // Completion ports gathered for the match loops
    logic                 cpl_done  [NUM_CPL];
    logic [XLEN-1:0]      cpl_pc    [NUM_CPL];
    logic [XLEN-1:0]      cpl_value [NUM_CPL];
    logic [ROB_DEPTH-1:0] cpl_hit   [NUM_CPL];          // One-hot per unit when unique

    logic [ROB_DEPTH-1:0] br_hit;                       // Branch entry match
    logic                 br_found;
    logic [ROB_IDX_W-1:0] br_idx;                       // Slot of the resolved branch
    logic [ROB_IDX_W-1:0] br_age;                       // Its distance from head
    logic [ROB_DEPTH-1:0] younger;                      // Entries behind the branch

    logic                 mispredict;
    logic                 alloc_fire;
    logic                 commit_fire;

    assign cpl_done[CPL_ALU]  = alu_done;
    assign cpl_pc[CPL_ALU]    = alu_pc;
    assign cpl_value[CPL_ALU] = alu_value;
    assign cpl_done[CPL_MUL]  = mul_done;
    assign cpl_pc[CPL_MUL]    = mul_pc;
    assign cpl_value[CPL_MUL] = mul_value;
    assign cpl_done[CPL_DIV]  = div_done;
    assign cpl_pc[CPL_DIV]    = div_pc;
    assign cpl_value[CPL_DIV] = div_value;

    // Parallel PC compare, one row per unit
    always_comb begin
        for (int u = 0; u < NUM_CPL; u++) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                cpl_hit[u][i] = cpl_done[u] && ent_valid[i] && (ent_pc[i] == cpl_pc[u]);
            end
        end
    end

    // Branch lookup, also yields the slot index
    always_comb begin
        br_found = 1'b0;
        br_idx   = '0;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            br_hit[i] = br_done && ent_valid[i] && ent_br[i] && (ent_pc[i] == br_pc);
            if (br_hit[i]) begin
                br_found = 1'b1;
                br_idx   = ROB_IDX_W'(i);
            end
        end
    end

    assign br_age = br_idx - head;                      // Wraps modulo depth

    // Age relative to head decides who is behind the branch
    always_comb begin
        logic [ROB_IDX_W-1:0] age;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            age        = ROB_IDX_W'(i) - head;
            younger[i] = age > br_age;
        end
    end

    assign rob_full    = (count == ROB_CNT_W'(ROB_DEPTH));
    assign mispredict  = br_done && br_taken && br_found;
    assign alloc_fire  = alloc && !rob_full && !mispredict; // Same-cycle dispatch is lost
    assign commit_fire = ent_valid[head] && ent_ready[head];

    // Control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                ent_valid[i] <= 1'b0;
                ent_ready[i] <= 1'b0;
            end
            head             <= '0;
            tail             <= '0;
            count            <= '0;
            commit_valid     <= 1'b0;
            commit_reg_write <= 1'b0;
        end else if (rob_flush) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                ent_valid[i] <= 1'b0;
                ent_ready[i] <= 1'b0;
            end
            head             <= '0;
            tail             <= '0;
            count            <= '0;
            commit_valid     <= 1'b0;               // Flush wins over commit
            commit_reg_write <= 1'b0;
        end else begin
            commit_valid     <= commit_fire;
            commit_reg_write <= commit_fire && ent_wr[head];

            // Results arriving from the units
            for (int u = 0; u < NUM_CPL; u++) begin
                for (int i = 0; i < ROB_DEPTH; i++) begin
                    if (cpl_hit[u][i]) begin
                        ent_ready[i] <= 1'b1;
                    end
                end
            end
            for (int i = 0; i < ROB_DEPTH; i++) begin
                if (br_hit[i]) begin
                    ent_ready[i] <= 1'b1;           // Branch done either way
                end
            end

            if (mispredict) begin
                for (int i = 0; i < ROB_DEPTH; i++) begin
                    if (younger[i]) begin           // Wrong-path entries
                        ent_valid[i] <= 1'b0;
                        ent_ready[i] <= 1'b0;
                    end
                end
                tail  <= br_idx + ROB_IDX_W'(1);
                // Branch and everything older stays, minus a commit
                count <= ROB_CNT_W'(br_age) + ROB_CNT_W'(1) - ROB_CNT_W'(commit_fire);
            end else begin
                if (alloc_fire) begin
                    ent_valid[tail] <= 1'b1;
                    ent_ready[tail] <= 1'b0;
                    tail            <= tail + ROB_IDX_W'(1);
                end
                count <= count + ROB_CNT_W'(alloc_fire) - ROB_CNT_W'(commit_fire);
            end

            if (commit_fire) begin
                ent_valid[head] <= 1'b0;
                ent_ready[head] <= 1'b0;
                head            <= head + ROB_IDX_W'(1);
            end
        end
    end

    // Payload, qualified by the valid bits above
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            ent_pc[tail]    <= alloc_pc;
            ent_dest[tail]  <= alloc_dest;
            ent_wr[tail]    <= alloc_writes_reg;
            ent_br[tail]    <= alloc_is_branch;
            ent_value[tail] <= '0;
        end
        for (int u = 0; u < NUM_CPL; u++) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                if (cpl_hit[u][i]) begin
                    ent_value[i] <= cpl_value[u];
                end
            end
        end
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (br_hit[i]) begin
                ent_value[i] <= br_target;          // Target recorded as the result
            end
        end
        if (commit_fire) begin
            commit_pc    <= ent_pc[head];
            commit_dest  <= ent_dest[head];
            commit_value <= ent_value[head];
        end
    end

    // Front end must stall on the full level
    a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
        !(alloc && rob_full))
        else $error("rob: dispatch while full, pc=%h", alloc_pc);

    // PC is the match key, so in-flight PCs must be distinct
    for (genvar u = 0; u < NUM_CPL; u++) begin : g_uniq
        a_cpl_unique: assert property (@(posedge clk) disable iff (rst)
            cpl_done[u] |-> $onehot0(cpl_hit[u]))
            else $error("rob: unit %0d pc %h matches several entries", u, cpl_pc[u]);
    end

    a_br_unique: assert property (@(posedge clk) disable iff (rst)
        br_done |-> $onehot0(br_hit))
        else $error("rob: branch pc %h matches several entries", br_pc);

endmodule

/* verilog/rob_dispatch_decode.sv */
`timescale 1ns/10ps

module rob_dispatch_decode (
    input  logic [isa_pkg::XLEN-1:0]      inst,          // Word from the front end
    output logic                          alloc,         // Real instruction, needs an entry
    output logic [isa_pkg::REG_IDX_W-1:0] dest,          // rd field
    output logic                          writes_reg,    // Commit will write rd
    output logic                          is_branch      // Resolved by the branch unit
);
    import isa_pkg::*;

    logic [OPC_W-1:0] opcode;                           // Major opcode field
    logic             wr_class;                         // Opcode class that produces rd

    assign opcode = inst[OPC_W-1:0];
    assign dest   = inst[RD_LSB +: REG_IDX_W];          // Valid field even when unused
    assign alloc  = |inst;                              // All-zero word is a bubble

    // Only these classes carry a result to the register file
    always_comb begin
        case (opcode)
            OPC_OP,
            OPC_OP_IMM,
            OPC_LUI,
            OPC_AUIPC,
            OPC_JAL,
            OPC_JALR,
            OPC_LOAD: wr_class = 1'b1;
            default:  wr_class = 1'b0;              // STORE, BRANCH, unknown
        endcase
    end

    assign writes_reg = alloc && wr_class && (dest != '0); // x0 target is dropped
    assign is_branch  = alloc && (opcode == OPC_BRANCH);

endmodule

/* verilog/rob_pkg.sv */
package rob_pkg;

    // Buffer geometry
    localparam int ROB_DEPTH = 64;                  // Entries in flight
    localparam int ROB_IDX_W = 6;                   // Head and tail pointer width
    localparam int ROB_CNT_W = 7;                   // Occupancy, must reach 64

    // Result sources that complete by PC
    // Branch unit is handled on its own path and is not counted here
    localparam int NUM_CPL   = 3;                   // ALU, MUL, DIV
    localparam int CPL_ALU   = 0;                   // Slot of the ALU port
    localparam int CPL_MUL   = 1;                   // Slot of the multiplier port
    localparam int CPL_DIV   = 2;                   // Slot of the divider port

endpackage

/* verilog/isa_pkg.sv */
package isa_pkg;

    // Word and PC width
    localparam int XLEN          = 32;

    // Architectural register file
    localparam int NUM_ARCH_REGS = 32;              // x0..x31
    localparam int REG_IDX_W     = 5;               // Enough for 32 regs

    // Instruction field layout
    localparam int OPC_W         = 7;               // Opcode in inst[6:0]
    localparam int RD_LSB        = 7;               // rd starts at inst[7]

    // Base opcodes (RV32I major map)
    localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011; // Reg-reg ALU and M ext
    localparam logic [OPC_W-1:0] OPC_OP_IMM = 7'b0010011; // Reg-imm ALU
    localparam logic [OPC_W-1:0] OPC_LUI    = 7'b0110111; // Upper immediate
    localparam logic [OPC_W-1:0] OPC_AUIPC  = 7'b0010111; // PC + upper immediate
    localparam logic [OPC_W-1:0] OPC_JAL    = 7'b1101111; // Jump, link to rd
    localparam logic [OPC_W-1:0] OPC_JALR   = 7'b1100111; // Indirect jump, link to rd
    localparam logic [OPC_W-1:0] OPC_LOAD   = 7'b0000011; // Loads write rd
    localparam logic [OPC_W-1:0] OPC_STORE  = 7'b0100011; // No rd
    localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011; // Conditional branch, no rd

endpackage
